// File: lc3_isa_pkg.sv
`default_nettype none

package lc3_isa_pkg;

    localparam int WORD_W   = 16;
    localparam int NUM_REGS = 8;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [2:0]        reg_idx_t;

    typedef enum logic [3:0] {
        OP_BR  = 4'b0000,
        OP_ADD = 4'b0001,
        OP_LD  = 4'b0010,
        OP_ST  = 4'b0011,
        OP_AND = 4'b0101,
        OP_NOT = 4'b1001,
        OP_LEA = 4'b1110
    } opcode_t;

    // ========================================
    // instruction fields
    // ========================================
    localparam int OPC_LSB = 12;
    localparam int DR_LSB  = 9;     // also the source of ST
    localparam int NZP_LSB = 9;     // BR condition bits
    localparam int SR1_LSB = 6;
    localparam int SR2_LSB = 0;
    localparam int IMM_BIT = 5;     // set for imm5 form
    localparam int IMM5_W  = 5;
    localparam int OFF6_W  = 6;
    localparam int OFF9_W  = 9;

    // condition codes, one hot
    localparam logic [2:0] NZP_N = 3'b100;
    localparam logic [2:0] NZP_Z = 3'b010;
    localparam logic [2:0] NZP_P = 3'b001;

    localparam word_t PC_RESET = 16'h3000;

endpackage

`default_nettype wire

// File: lc3_ctrl_pkg.sv
`default_nettype none

package lc3_ctrl_pkg;

    // ========================================
    // datapath select encodings
    // ========================================
    typedef enum logic [1:0] {
        BUS_ADDR = 2'b00,
        BUS_ALU  = 2'b01,
        BUS_MDR  = 2'b10,
        BUS_PC   = 2'b11
    } bus_sel_t;

    typedef enum logic [1:0] {
        PC_INC  = 2'b00,
        PC_ADDR = 2'b10,
        PC_BUS  = 2'b11
    } pc_sel_t;

    typedef enum logic {
        ADDR1_PC  = 1'b0,
        ADDR1_SR1 = 1'b1
    } addr1_sel_t;

    typedef enum logic [1:0] {
        ADDR2_ZERO = 2'b00,
        ADDR2_OFF6 = 2'b01,
        ADDR2_OFF9 = 2'b10
    } addr2_sel_t;

    typedef enum logic [1:0] {
        ALU_ADD  = 2'b00,
        ALU_AND  = 2'b01,
        ALU_NOT  = 2'b10,
        ALU_PASS = 2'b11
    } alu_op_t;

    // register number selects
    localparam logic DR_SEL_R7  = 1'b0;
    localparam logic DR_SEL_IR  = 1'b1;     // IR[11:9]
    localparam logic SR1_SEL_HI = 1'b0;     // IR[11:9]
    localparam logic SR1_SEL_LO = 1'b1;     // IR[8:6]

    // ========================================
    // memory port
    // ========================================
    localparam int MEM_CREDITS = 2;
    localparam int CREDIT_W    = $clog2(MEM_CREDITS + 1);

endpackage

`default_nettype wire

// File: lc3_exec.sv
`timescale 1ns/1ps
`default_nettype none

module lc3_exec (
    input  lc3_isa_pkg::word_t       ir,
    input  lc3_isa_pkg::word_t       sr1_val,
    input  lc3_isa_pkg::word_t       sr2_val,
    input  lc3_isa_pkg::word_t       pc,
    input  lc3_ctrl_pkg::alu_op_t    alu_op,
    input  lc3_ctrl_pkg::addr1_sel_t addr1_sel,
    input  lc3_ctrl_pkg::addr2_sel_t addr2_sel,
    output lc3_isa_pkg::word_t       alu_out,
    output lc3_isa_pkg::word_t       addr_out
);

    import lc3_isa_pkg::*;
    import lc3_ctrl_pkg::*;

    word_t imm5;
    word_t off6;
    word_t off9;
    word_t alu_b;
    word_t addr1;
    word_t addr2;

    // sign extension
    assign imm5 = {{(WORD_W-IMM5_W){ir[IMM5_W-1]}}, ir[IMM5_W-1:0]};
    assign off6 = {{(WORD_W-OFF6_W){ir[OFF6_W-1]}}, ir[OFF6_W-1:0]};
    assign off9 = {{(WORD_W-OFF9_W){ir[OFF9_W-1]}}, ir[OFF9_W-1:0]};

    // ========================================
    // ALU
    // ========================================
    assign alu_b = ir[IMM_BIT] ? imm5 : sr2_val;

    always_comb
    begin
        case (alu_op)
            ALU_ADD: alu_out = sr1_val + alu_b;
            ALU_AND: alu_out = sr1_val & alu_b;
            ALU_NOT: alu_out = ~sr1_val;
            default: alu_out = sr1_val;     // pass
        endcase
    end

    // ========================================
    // address adder
    // ========================================
    assign addr1 = (addr1_sel == ADDR1_SR1) ? sr1_val : pc;

    always_comb
    begin
        case (addr2_sel)
            ADDR2_OFF6: addr2 = off6;
            ADDR2_OFF9: addr2 = off9;
            default:    addr2 = '0;
        endcase
    end

    assign addr_out = addr1 + addr2;

endmodule

`default_nettype wire

// File: lc3_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module lc3_reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  lc3_isa_pkg::word_t ir,
    input  lc3_isa_pkg::word_t bus,
    input  logic               ld_reg,
    input  logic               ld_cc,
    input  logic               dr_sel,
    input  logic               sr1_sel,
    output lc3_isa_pkg::word_t sr1_val,
    output lc3_isa_pkg::word_t sr2_val,
    output logic [2:0]         nzp
);

    import lc3_isa_pkg::*;
    import lc3_ctrl_pkg::*;

    word_t               regs [NUM_REGS];
    logic [NUM_REGS-1:0] reg_we;
    reg_idx_t            dr;
    reg_idx_t            sr1;
    reg_idx_t            sr2;

    assign dr  = (dr_sel == DR_SEL_R7) ? reg_idx_t'(3'b111) : ir[DR_LSB +: 3];
    assign sr1 = (sr1_sel == SR1_SEL_HI) ? ir[DR_LSB +: 3] : ir[SR1_LSB +: 3];
    assign sr2 = ir[SR2_LSB +: 3];

    // one write enable per register
    always_comb
    begin
        reg_we = '0;
        if (ld_reg)
            reg_we[dr] = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            regs <= '{default: '0};
        else
            for (int i = 0; i < NUM_REGS; i++)
                if (reg_we[i])
                    regs[i] <= bus;
    end

    assign sr1_val = regs[sr1];
    assign sr2_val = regs[sr2];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            nzp <= NZP_Z;
        else if (ld_cc)
        begin
            if (bus[WORD_W-1])
                nzp <= NZP_N;
            else if (bus == '0)
                nzp <= NZP_Z;
            else
                nzp <= NZP_P;
        end
    end

endmodule

`default_nettype wire

// File: lc3_bus_unit.sv
`timescale 1ns/1ps
`default_nettype none

module lc3_bus_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ld_ir,
    input  logic                   ld_pc,
    input  logic                   ld_mar,
    input  logic                   ld_mdr,
    input  lc3_ctrl_pkg::bus_sel_t bus_sel,
    input  lc3_ctrl_pkg::pc_sel_t  pc_sel,
    input  logic                   mio_en,
    input  lc3_isa_pkg::word_t     alu_out,
    input  lc3_isa_pkg::word_t     addr_out,
    input  lc3_isa_pkg::word_t     mem_rdata,
    output lc3_isa_pkg::word_t     bus,
    output lc3_isa_pkg::word_t     pc,
    output lc3_isa_pkg::word_t     ir,
    output lc3_isa_pkg::word_t     mar,
    output lc3_isa_pkg::word_t     mdr
);

    import lc3_isa_pkg::*;
    import lc3_ctrl_pkg::*;

    word_t pc_in;
    word_t mdr_in;

    // ========================================
    // multiplexers
    // ========================================
    always_comb
    begin
        case (bus_sel)
            BUS_ADDR: bus = addr_out;
            BUS_ALU:  bus = alu_out;
            BUS_MDR:  bus = mdr;
            default:  bus = pc;
        endcase
    end

    always_comb
    begin
        case (pc_sel)
            PC_ADDR: pc_in = addr_out;
            PC_BUS:  pc_in = bus;
            default: pc_in = pc + 16'd1;
        endcase
    end

    assign mdr_in = mio_en ? mem_rdata : bus;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc  <= PC_RESET;
            mar <= PC_RESET;    // first fetch address
        end
        else
        begin
            if (ld_pc)
                pc <= pc_in;
            if (ld_mar)
                mar <= bus;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ld_ir)
            ir <= bus;
        if (ld_mdr)
            mdr <= mdr_in;
    end

endmodule

`default_nettype wire

// File: lc3_control.sv
`timescale 1ns/1ps
`default_nettype none

module lc3_control (
    input  logic                     clk,
    input  logic                     rst_n,
    input  lc3_isa_pkg::word_t       ir,
    input  logic [2:0]               nzp,
    input  logic                     mem_credit,
    input  logic                     mem_rsp_valid,
    output logic                     mem_req_valid,
    output logic                     mem_req_write,
    output logic                     ld_ir,
    output logic                     ld_pc,
    output logic                     ld_mar,
    output logic                     ld_mdr,
    output logic                     ld_reg,
    output logic                     ld_cc,
    output lc3_ctrl_pkg::bus_sel_t   bus_sel,
    output lc3_ctrl_pkg::pc_sel_t    pc_sel,
    output logic                     mio_en,
    output logic                     dr_sel,
    output logic                     sr1_sel,
    output lc3_ctrl_pkg::alu_op_t    alu_op,
    output lc3_ctrl_pkg::addr1_sel_t addr1_sel,
    output lc3_ctrl_pkg::addr2_sel_t addr2_sel
);

    import lc3_isa_pkg::*;
    import lc3_ctrl_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_FETCH,
        S_FETCH_WAIT,
        S_LOAD_IR,
        S_DECODE,
        S_EXEC,
        S_LD_ISSUE,
        S_LD_WAIT,
        S_LD_WB,
        S_ST_MDR,
        S_ST_ISSUE
    } state_t;

    state_t              state;
    state_t              state_next;
    logic [CREDIT_W-1:0] credits;
    logic                has_credit;
    logic                br_taken;
    opcode_t             opcode;

    assign opcode     = opcode_t'(ir[OPC_LSB +: $bits(opcode_t)]);
    assign br_taken   = |(ir[NZP_LSB +: 3] & nzp);
    assign has_credit = (credits != '0);

    // ========================================
    // credit counter
    // ========================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            credits <= CREDIT_W'(MEM_CREDITS);
        else if (mem_req_valid && !mem_credit)
            credits <= credits - CREDIT_W'(1);
        else if (!mem_req_valid && mem_credit)
            credits <= credits + CREDIT_W'(1);
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= S_IDLE;
        else
            state <= state_next;
    end

    // ========================================
    // control word
    // ========================================
    always_comb
    begin
        state_next    = state;
        mem_req_valid = 1'b0;
        mem_req_write = 1'b0;
        ld_ir         = 1'b0;
        ld_pc         = 1'b0;
        ld_mar        = 1'b0;
        ld_mdr        = 1'b0;
        ld_reg        = 1'b0;
        ld_cc         = 1'b0;
        bus_sel       = BUS_PC;
        pc_sel        = PC_INC;
        mio_en        = 1'b0;
        dr_sel        = DR_SEL_IR;
        sr1_sel       = SR1_SEL_LO;
        alu_op        = ALU_PASS;
        addr1_sel     = ADDR1_PC;
        addr2_sel     = ADDR2_ZERO;
        case (state)
            S_IDLE:
                state_next = S_FETCH;
            S_FETCH:
                if (has_credit)
                begin
                    mem_req_valid = 1'b1;       // MAR holds PC here
                    ld_pc         = 1'b1;
                    state_next    = S_FETCH_WAIT;
                end
            S_FETCH_WAIT:
                if (mem_rsp_valid)
                begin
                    mio_en     = 1'b1;
                    ld_mdr     = 1'b1;
                    state_next = S_LOAD_IR;
                end
            S_LOAD_IR:
            begin
                bus_sel    = BUS_MDR;
                ld_ir      = 1'b1;
                state_next = S_DECODE;
            end
            S_DECODE:
            begin
                ld_mar     = 1'b1;              // next PC, or data address
                state_next = S_EXEC;
                if (opcode == OP_LD || opcode == OP_ST)
                begin
                    bus_sel    = BUS_ADDR;
                    addr2_sel  = ADDR2_OFF9;
                    state_next = (opcode == OP_LD) ? S_LD_ISSUE : S_ST_MDR;
                end
            end
            S_EXEC:
            begin
                state_next = S_FETCH;
                case (opcode)
                    OP_ADD, OP_AND, OP_NOT:
                    begin
                        alu_op  = (opcode == OP_ADD) ? ALU_ADD :
                                  (opcode == OP_AND) ? ALU_AND : ALU_NOT;
                        bus_sel = BUS_ALU;
                        ld_reg  = 1'b1;
                        ld_cc   = 1'b1;
                    end
                    OP_LEA:
                    begin
                        addr2_sel = ADDR2_OFF9;
                        bus_sel   = BUS_ADDR;
                        ld_reg    = 1'b1;               // leaves CC alone
                    end
                    OP_BR:
                        if (br_taken)
                        begin
                            addr2_sel = ADDR2_OFF9;
                            bus_sel   = BUS_ADDR;
                            pc_sel    = PC_ADDR;
                            ld_pc     = 1'b1;
                            ld_mar    = 1'b1;           // fetch from target
                        end
                    default:
                        ;                               // unknown opcode is a nop
                endcase
            end
            S_LD_ISSUE:
                if (has_credit)
                begin
                    mem_req_valid = 1'b1;
                    ld_mar        = 1'b1;       // MAR back to PC
                    state_next    = S_LD_WAIT;
                end
            S_LD_WAIT:
                if (mem_rsp_valid)
                begin
                    mio_en     = 1'b1;
                    ld_mdr     = 1'b1;
                    state_next = S_LD_WB;
                end
            S_LD_WB:
            begin
                bus_sel    = BUS_MDR;
                ld_reg     = 1'b1;
                ld_cc      = 1'b1;
                state_next = S_FETCH;
            end
            S_ST_MDR:
            begin
                sr1_sel    = SR1_SEL_HI;
                bus_sel    = BUS_ALU;
                ld_mdr     = 1'b1;
                state_next = S_ST_ISSUE;
            end
            S_ST_ISSUE:
                if (has_credit)
                begin
                    mem_req_valid = 1'b1;
                    mem_req_write = 1'b1;       // posted, no response
                    ld_mar        = 1'b1;
                    state_next    = S_FETCH;
                end
            default:
                state_next = S_IDLE;
        endcase
    end

endmodule

`default_nettype wire

// File: lc3_datapath_top.sv
`timescale 1ns/1ps
`default_nettype none

module lc3_datapath_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mem_credit,
    input  logic               mem_rsp_valid,
    input  lc3_isa_pkg::word_t mem_rdata,
    output logic               mem_req_valid,
    output logic               mem_req_write,
    output lc3_isa_pkg::word_t mem_addr,
    output lc3_isa_pkg::word_t mem_wdata
);

    import lc3_isa_pkg::*;
    import lc3_ctrl_pkg::*;

    // control word
    logic       ld_ir;
    logic       ld_pc;
    logic       ld_mar;
    logic       ld_mdr;
    logic       ld_reg;
    logic       ld_cc;
    bus_sel_t   bus_sel;
    pc_sel_t    pc_sel;
    logic       mio_en;
    logic       dr_sel;
    logic       sr1_sel;
    alu_op_t    alu_op;
    addr1_sel_t addr1_sel;
    addr2_sel_t addr2_sel;

    // datapath
    word_t      bus;
    word_t      pc;
    word_t      ir;
    word_t      sr1_val;
    word_t      sr2_val;
    word_t      alu_out;
    word_t      addr_out;
    logic [2:0] nzp;

    lc3_control u_control (
        .clk           (clk),
        .rst_n         (rst_n),
        .ir            (ir),
        .nzp           (nzp),
        .mem_credit    (mem_credit),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .ld_ir         (ld_ir),
        .ld_pc         (ld_pc),
        .ld_mar        (ld_mar),
        .ld_mdr        (ld_mdr),
        .ld_reg        (ld_reg),
        .ld_cc         (ld_cc),
        .bus_sel       (bus_sel),
        .pc_sel        (pc_sel),
        .mio_en        (mio_en),
        .dr_sel        (dr_sel),
        .sr1_sel       (sr1_sel),
        .alu_op        (alu_op),
        .addr1_sel     (addr1_sel),
        .addr2_sel     (addr2_sel)
    );

    lc3_bus_unit u_bus (
        .clk       (clk),
        .rst_n     (rst_n),
        .ld_ir     (ld_ir),
        .ld_pc     (ld_pc),
        .ld_mar    (ld_mar),
        .ld_mdr    (ld_mdr),
        .bus_sel   (bus_sel),
        .pc_sel    (pc_sel),
        .mio_en    (mio_en),
        .alu_out   (alu_out),
        .addr_out  (addr_out),
        .mem_rdata (mem_rdata),
        .bus       (bus),
        .pc        (pc),
        .ir        (ir),
        .mar       (mem_addr),      // MAR drives the request address
        .mdr       (mem_wdata)
    );

    lc3_reg_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .ir      (ir),
        .bus     (bus),
        .ld_reg  (ld_reg),
        .ld_cc   (ld_cc),
        .dr_sel  (dr_sel),
        .sr1_sel (sr1_sel),
        .sr1_val (sr1_val),
        .sr2_val (sr2_val),
        .nzp     (nzp)
    );

    lc3_exec u_exec (
        .ir        (ir),
        .sr1_val   (sr1_val),
        .sr2_val   (sr2_val),
        .pc        (pc),
        .alu_op    (alu_op),
        .addr1_sel (addr1_sel),
        .addr2_sel (addr2_sel),
        .alu_out   (alu_out),
        .addr_out  (addr_out)
    );

endmodule

`default_nettype wire

// File: tb_lc3_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lc3_mem (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    input  logic               req_write,
    input  lc3_isa_pkg::word_t addr,
    input  lc3_isa_pkg::word_t wdata,
    output logic               credit,
    output logic               rsp_valid,
    output lc3_isa_pkg::word_t rdata
);

    import lc3_isa_pkg::*;

    word_t mem [0:65535];
    int    cycle;
    int    credit_last;
    int    credit_due [$];
    int    rsp_due [$];
    word_t rsp_data [$];

    initial
    begin
        for (int a = 0; a < 65536; a++)
            mem[a] = word_t'(a) ^ 16'hc35a;     // background pattern
        credit      = 1'b0;
        rsp_valid   = 1'b0;
        rdata       = '0;
        cycle       = 0;
        credit_last = 0;
    end

    // requests are stable mid cycle and taken at the next rising edge
    always @(negedge clk)
    begin
        if (rst_n && req_valid)
        begin
            if (credit_last < cycle)
                credit_last = cycle;
            credit_last = credit_last + int'($urandom_range(1, 4));   // returned one at a time
            credit_due.push_back(credit_last);
            if (req_write)
                mem[addr] = wdata;              // posted store
            else
            begin
                rsp_due.push_back(cycle + int'($urandom_range(1, 4)));
                rsp_data.push_back(mem[addr]);
            end
        end
    end

    // ========================================
    // credit and response pulses
    // ========================================
    always @(posedge clk)
    begin
        #1;
        cycle     = cycle + 1;
        credit    = 1'b0;
        rsp_valid = 1'b0;
        if (!rst_n)
        begin
            credit_due.delete();
            rsp_due.delete();
            rsp_data.delete();
            credit_last = cycle;
        end
        else
        begin
            if (credit_due.size() > 0 && credit_due[0] <= cycle)
            begin
                credit = 1'b1;                  // one credit per cycle
                void'(credit_due.pop_front());
            end
            if (rsp_due.size() > 0 && rsp_due[0] <= cycle)
            begin
                rsp_valid = 1'b1;               // in request order
                rdata     = rsp_data.pop_front();
                void'(rsp_due.pop_front());
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_lc3.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lc3;

    import lc3_isa_pkg::*;
    import lc3_ctrl_pkg::*;

    localparam int    NUM_PROGRAMS = 3;
    localparam int    BODY_LEN     = 30;
    localparam int    PROG_LEN     = BODY_LEN + NUM_REGS + 1;
    localparam int    CYCLE_LIMIT  = 200 * PROG_LEN * NUM_PROGRAMS;
    localparam int    DATA_WORDS   = 16;
    localparam word_t DATA_BASE    = 16'h3040;
    localparam word_t RES_BASE     = 16'h3060;
    localparam word_t HALT_ADDR    = PC_RESET + word_t'(PROG_LEN - 1);

    logic        clk;
    logic        rst_n;
    logic        mem_credit;
    logic        mem_rsp_valid;
    logic        mem_req_valid;
    logic        mem_req_write;
    word_t       mem_rdata;
    word_t       mem_addr;
    word_t       mem_wdata;

    word_t       model_mem [0:65535];
    logic [32:0] exp_req [$];           // write, address, store data
    logic        checking;
    int          outstanding;
    int          errors;
    int          cycles;
    int          passed;

    lc3_datapath_top u_lc3_datapath_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_credit    (mem_credit),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rdata     (mem_rdata),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata)
    );

    tb_lc3_mem u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (mem_req_valid),
        .req_write (mem_req_write),
        .addr      (mem_addr),
        .wdata     (mem_wdata),
        .credit    (mem_credit),
        .rsp_valid (mem_rsp_valid),
        .rdata     (mem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout, the core stopped making progress after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // ========================================
    // program generation
    // ========================================
    function automatic reg_idx_t rand_reg();
        return reg_idx_t'($urandom_range(0, 7));
    endfunction

    // imm5 form or SR2 form
    function automatic logic [5:0] rand_operand();
        if ($urandom_range(0, 1) == 1)
            return {1'b1, 5'($urandom)};
        else
            return {3'b000, rand_reg()};
    endfunction

    function automatic logic [8:0] pc_offset(input word_t from, input word_t target);
        word_t diff;
        diff = target - (from + 16'd1);
        return diff[8:0];
    endfunction

    task automatic put_word(input word_t a, input word_t v);
        model_mem[a] = v;
        u_mem.mem[a] = v;
    endtask

    task automatic gen_program();
        word_t addr;
        word_t ins;
        int    kind;
        int    idx;
        int    span;
        int    last_st;
        last_st = -1;
        for (int i = 0; i < DATA_WORDS; i++)
            put_word(DATA_BASE + word_t'(i), word_t'($urandom));
        for (int i = 0; i < BODY_LEN; i++)
        begin
            addr = PC_RESET + word_t'(i);
            kind = int'($urandom_range(0, 7));
            idx  = int'($urandom_range(0, DATA_WORDS - 1));
            case (kind)
                0, 1: ins = {OP_ADD, rand_reg(), rand_reg(), rand_operand()};
                2:    ins = {OP_AND, rand_reg(), rand_reg(), rand_operand()};
                3:    ins = {OP_NOT, rand_reg(), rand_reg(), 6'b111111};
                4:
                begin
                    if (last_st >= 0 && $urandom_range(0, 1) == 1)
                        idx = last_st;              // read back a stored word
                    ins = {OP_LD, rand_reg(), pc_offset(addr, DATA_BASE + word_t'(idx))};
                end
                5:
                begin
                    last_st = idx;
                    ins = {OP_ST, rand_reg(), pc_offset(addr, DATA_BASE + word_t'(idx))};
                end
                6:    ins = {OP_LEA, rand_reg(), 9'($urandom)};
                default:
                begin
                    span = BODY_LEN - 1 - i;        // forward only
                    if (span > 3)
                        span = 3;
                    ins = {OP_BR, 3'($urandom_range(0, 7)), 9'($urandom_range(0, span))};
                end
            endcase
            put_word(addr, ins);
        end
        for (int r = 0; r < NUM_REGS; r++)
        begin
            addr = PC_RESET + word_t'(BODY_LEN + r);
            put_word(addr, {OP_ST, reg_idx_t'(r), pc_offset(addr, RES_BASE + word_t'(r))});
        end
        put_word(HALT_ADDR, {OP_BR, 3'b111, 9'h1ff});     // branch to itself
    endtask

    // ========================================
    // ISA model
    // ========================================
    function automatic word_t sign_extend(input word_t value, input int width);
        word_t v;
        v = value;
        for (int b = width; b < WORD_W; b++)
            v[b] = value[width-1];
        return v;
    endfunction

    function automatic logic [2:0] cond_code(input word_t v);
        if (v[WORD_W-1])
            return NZP_N;
        else if (v == '0)
            return NZP_Z;
        else
            return NZP_P;
    endfunction

    task automatic run_model(output int stores);
        word_t      r [NUM_REGS];
        word_t      pc;
        word_t      ins;
        word_t      ea;
        word_t      operand;
        reg_idx_t   dr;
        reg_idx_t   sr1;
        logic [2:0] cc;
        logic       halted;
        int         steps;
        stores = 0;
        steps  = 0;
        halted = 1'b0;
        pc     = PC_RESET;
        cc     = NZP_Z;
        for (int i = 0; i < NUM_REGS; i++)
            r[i] = '0;
        exp_req.delete();
        while (!halted && steps <= PROG_LEN)
        begin
            exp_req.push_back({1'b0, pc, 16'h0000});
            ins     = model_mem[pc];
            halted  = (pc == HALT_ADDR);
            pc      = pc + 16'd1;
            dr      = ins[11:9];
            sr1     = ins[8:6];
            ea      = pc + sign_extend(16'(ins[8:0]), 9);
            operand = ins[5] ? sign_extend(16'(ins[4:0]), 5) : r[ins[2:0]];
            case (ins[15:12])
                OP_ADD:
                begin
                    r[dr] = r[sr1] + operand;
                    cc    = cond_code(r[dr]);
                end
                OP_AND:
                begin
                    r[dr] = r[sr1] & operand;
                    cc    = cond_code(r[dr]);
                end
                OP_NOT:
                begin
                    r[dr] = ~r[sr1];
                    cc    = cond_code(r[dr]);
                end
                OP_LD:
                begin
                    exp_req.push_back({1'b0, ea, 16'h0000});
                    r[dr] = model_mem[ea];
                    cc    = cond_code(r[dr]);
                end
                OP_ST:
                begin
                    exp_req.push_back({1'b1, ea, r[dr]});
                    model_mem[ea] = r[dr];
                    stores++;
                end
                OP_LEA: r[dr] = ea;                 // CC unchanged
                OP_BR:
                    if ((ins[11:9] & cc) != 3'b000)
                        pc = ea;
                default: ;
            endcase
            steps++;
        end
        exp_req.push_back({1'b0, pc, 16'h0000});   // fetch after the halt branch
    endtask

    // ========================================
    // request monitor
    // ========================================
    task automatic check_request();
        logic [32:0] exp;
        if (exp_req.size() == 0)
        begin
            $display("request at %0t to address %h came after the program ended", $time, mem_addr);
            errors++;
        end
        else
        begin
            exp = exp_req.pop_front();
            if (mem_req_write !== exp[32])
            begin
                $display("Error at %0t: mem_req_write is %b, expected %b",
                         $time, mem_req_write, exp[32]);
                errors++;
            end
            if (mem_addr !== exp[31:16])
            begin
                $display("Error at %0t: mem_addr is %h, expected %h", $time, mem_addr, exp[31:16]);
                errors++;
            end
            if (exp[32] && mem_wdata !== exp[15:0])
            begin
                $display("Error at %0t: mem_wdata is %h, expected %h", $time, mem_wdata, exp[15:0]);
                errors++;
            end
        end
    endtask

    always @(negedge clk)
    begin
        if (!rst_n)
            outstanding = 0;
        else
        begin
            if (mem_credit)
                outstanding = outstanding - 1;
            if (mem_req_valid)
            begin
                outstanding = outstanding + 1;
                if (outstanding > MEM_CREDITS)
                begin
                    $display("at %0t the core had %0d requests outstanding with only %0d credits",
                             $time, outstanding, MEM_CREDITS);
                    errors++;
                end
                if (checking)
                    check_request();
            end
        end
    end

    task automatic run_program(input int num);
        int stores;
        int n_req;
        int err_start;
        @(posedge clk);
        #1;
        rst_n    = 1'b0;
        checking = 1'b0;
        repeat (4) @(posedge clk);
        gen_program();
        run_model(stores);
        n_req     = exp_req.size();
        err_start = errors;
        checking  = 1'b1;
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        if (mem_req_valid !== 1'b0)
        begin
            $display("Error at %0t: mem_req_valid is %b, expected 0", $time, mem_req_valid);
            errors++;
        end
        while (exp_req.size() != 0)
            @(posedge clk);
        checking = 1'b0;
        if (errors == err_start)
            passed++;
        $display("program %0d: %s, %0d requests and %0d stores checked", num,
                 (errors == err_start) ? "pass" : "FAIL", n_req, stores);
    endtask

    initial
    begin
        void'($urandom(32'h6d8c_b957));
        rst_n       = 1'b0;
        checking    = 1'b0;
        outstanding = 0;
        errors      = 0;
        cycles      = 0;
        passed      = 0;
        for (int t = 0; t < NUM_PROGRAMS; t++)
            run_program(t);
        $display("%0d of %0d programs passed, %0d errors", passed, NUM_PROGRAMS, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
lc3_isa_pkg.sv
lc3_ctrl_pkg.sv
lc3_exec.sv
lc3_reg_file.sv
lc3_bus_unit.sv
lc3_control.sv
lc3_datapath_top.sv
tb_lc3_mem.sv
tb_lc3.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lc3
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILE_LIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf $(BUILD_DIR)
